// File: verilog/soc_pkg.sv
// SoC package with the address map, register addresses, sizes and the flash configuration word
`default_nettype none

package soc_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8; // One strobe per byte lane

	localparam int ram_words = 256;
	localparam int ram_addr_w = $clog2(ram_words); // Word index into the RAM
	localparam int flash_addr_w = 24; // Byte offset inside the flash region

	// Region codes live in the top address byte
	localparam logic [7:0] region_ram = 8'h00;
	localparam logic [7:0] region_flash = 8'h01;
	localparam logic [7:0] region_regs = 8'h02;
	localparam logic [7:0] region_io = 8'h03; // This code and everything above goes off chip

	localparam logic [addr_w-1:0] reg_spi_cfg = 32'h0200_0000;
	localparam logic [addr_w-1:0] reg_uart_div = 32'h0200_0004;
	localparam logic [addr_w-1:0] reg_uart_dat = 32'h0200_0008;

	localparam logic [7:0] spi_read_cmd = 8'h03; // Plain single-bit read opcode

	localparam logic [data_w-1:0] uart_div_reset = 32'd64; // Clocks per bit after reset

	localparam logic [data_w-1:0] spi_cfg_reset = 32'h8000_0000; // Memory mode on
	localparam logic [data_w-1:0] spi_cfg_mask = 32'h8000_0131; // Bits that hold state

	// Flash configuration word, written raw through byte strobes and decoded by field
	typedef union packed {
		logic [data_w-1:0] raw;
		struct packed {
			logic mem_en; // Bit 31 selects the read engine over bit-bang
			logic [21:0] rsv_hi;
			logic bb_oe; // Bit 8
			logic [1:0] rsv_mid;
			logic bb_clk; // Bit 5
			logic bb_csb; // Bit 4
			logic [2:0] rsv_lo;
			logic bb_mosi; // Bit 0
		} f;
	} spi_cfg_u;

endpackage

`default_nettype wire

// File: verilog/mem_bus_fabric.sv
// Bus fabric that decodes the master address into block selects and returns ready and read data
`timescale 1ns/10ps
`default_nettype none

module mem_bus_fabric (
	input wire mem_valid,
	input wire [soc_pkg::addr_w-1:0] mem_addr,
	input wire [soc_pkg::data_w-1:0] mem_wdata,
	input wire [soc_pkg::strb_w-1:0] mem_wstrb,
	output logic mem_ready,
	output logic [soc_pkg::data_w-1:0] mem_rdata,

	output logic iomem_valid,
	input wire iomem_ready,
	output logic [soc_pkg::addr_w-1:0] iomem_addr,
	output logic [soc_pkg::data_w-1:0] iomem_wdata,
	output logic [soc_pkg::strb_w-1:0] iomem_wstrb,
	input wire [soc_pkg::data_w-1:0] iomem_rdata,

	output logic ram_valid,
	input wire ram_ready,
	input wire [soc_pkg::data_w-1:0] ram_rdata,
	output logic flash_valid,
	input wire flash_ready,
	input wire [soc_pkg::data_w-1:0] flash_rdata,
	output logic [soc_pkg::strb_w-1:0] spi_cfg_we,
	input wire [soc_pkg::data_w-1:0] spi_cfg_rdata,
	output logic [soc_pkg::strb_w-1:0] uart_div_we,
	input wire [soc_pkg::data_w-1:0] uart_div_rdata,
	output logic uart_dat_we,
	output logic uart_dat_re,
	input wire [soc_pkg::data_w-1:0] uart_dat_rdata,
	input wire uart_dat_wait
);
	import soc_pkg::*;

	logic [7:0] region;
	logic ram_sel, flash_sel, regs_sel, io_sel;
	logic cfg_sel, div_sel, dat_sel, unmapped_sel;
	logic is_read;

	assign region = mem_addr[addr_w-1:addr_w-8];
	assign is_read = (mem_wstrb == '0);

	assign ram_sel = mem_valid && (region == region_ram);
	assign flash_sel = mem_valid && (region == region_flash);
	assign regs_sel = mem_valid && (region == region_regs);
	assign io_sel = mem_valid && (region >= region_io);

	assign cfg_sel = regs_sel && (mem_addr == reg_spi_cfg);
	assign div_sel = regs_sel && (mem_addr == reg_uart_div);
	assign dat_sel = regs_sel && (mem_addr == reg_uart_dat);
	assign unmapped_sel = regs_sel && !cfg_sel && !div_sel && !dat_sel; // Completes with zero data

	assign ram_valid = ram_sel && !ram_ready; // Low in the response cycle so the RAM fires once
	assign flash_valid = flash_sel;

	assign spi_cfg_we = cfg_sel ? mem_wstrb : '0;
	assign uart_div_we = div_sel ? mem_wstrb : '0;
	assign uart_dat_we = dat_sel && mem_wstrb[0]; // Only the low byte carries a character
	assign uart_dat_re = dat_sel && is_read;

	// External I/O sees the master bus unchanged
	assign iomem_valid = io_sel;
	assign iomem_addr = mem_addr;
	assign iomem_wdata = mem_wdata;
	assign iomem_wstrb = mem_wstrb;

	assign mem_ready = (ram_sel && ram_ready) || (flash_sel && flash_ready) ||
		(io_sel && iomem_ready) || cfg_sel || div_sel || unmapped_sel ||
		(dat_sel && !uart_dat_wait);

	always_comb begin
		mem_rdata = '0;
		if (ram_sel)
			mem_rdata = ram_rdata;
		else if (flash_sel)
			mem_rdata = flash_rdata;
		else if (io_sel)
			mem_rdata = iomem_rdata;
		else if (cfg_sel)
			mem_rdata = spi_cfg_rdata;
		else if (div_sel)
			mem_rdata = uart_div_rdata;
		else if (dat_sel)
			mem_rdata = uart_dat_rdata;
	end

endmodule

`default_nettype wire

// File: verilog/sram_words.sv
// On-chip word RAM with byte-strobe writes and a registered one-cycle response
`timescale 1ns/10ps
`default_nettype none

module sram_words (
	input wire clk,
	input wire valid,
	input wire [soc_pkg::ram_addr_w-1:0] addr,
	input wire [soc_pkg::data_w-1:0] wdata,
	input wire [soc_pkg::strb_w-1:0] wstrb,
	output logic ready,
	output logic [soc_pkg::data_w-1:0] rdata
);
	import soc_pkg::*;

	logic [data_w-1:0] mem [ram_words];

	// The fabric drops valid while ready is high, so ready is a single pulse
	always_ff @(posedge clk) begin
		ready <= valid;
	end

	always_ff @(posedge clk) begin
		if (valid) begin
			rdata <= mem[addr]; // Old contents, even on a write
			for (int i = 0; i < strb_w; i++) begin
				if (wstrb[i])
					mem[addr][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/spi_flash_reader.sv
// Serial flash reader that turns bus reads into SPI read commands, with a bit-bang config register
`timescale 1ns/10ps
`default_nettype none

module spi_flash_reader (
	input wire clk,
	input wire rst_n,
	input wire valid,
	input wire [soc_pkg::flash_addr_w-1:0] addr,
	output logic ready,
	output logic [soc_pkg::data_w-1:0] rdata,
	input wire [soc_pkg::strb_w-1:0] cfg_we,
	input wire [soc_pkg::data_w-1:0] cfg_wdata,
	output logic [soc_pkg::data_w-1:0] cfg_rdata,
	output logic flash_csb,
	output logic flash_clk,
	output logic flash_mosi,
	input wire flash_miso
);
	import soc_pkg::*;

	spi_cfg_u cfg;
	spi_cfg_u cfg_next;
	logic busy; // A read transfer is on the pins
	logic spi_csb;
	logic spi_clk;
	logic [5:0] bit_cnt; // Rising edge number within the 64-bit frame
	logic [31:0] tx_shift;
	logic [31:0] rx_shift;
	logic start;
	logic advance;

	// Byte strobes merge into the current word, unused bits stay zero
	always_comb begin
		cfg_next = cfg;
		for (int i = 0; i < strb_w; i++) begin
			if (cfg_we[i])
				cfg_next.raw[8*i +: 8] = cfg_wdata[8*i +: 8];
		end
		cfg_next.raw = cfg_next.raw & spi_cfg_mask;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cfg.raw <= spi_cfg_reset;
		else
			cfg <= cfg_next;
	end

	assign cfg_rdata = cfg.raw;

	// No new read in the ready cycle, the master still holds the finished request
	assign start = !busy && !ready && valid && cfg.f.mem_en;
	assign advance = busy && cfg.f.mem_en; // Transfer freezes while bit-bang owns the pins

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			ready <= 1'b0;
			spi_csb <= 1'b1;
			spi_clk <= 1'b0;
			bit_cnt <= '0;
		end else begin
			ready <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				spi_csb <= 1'b0;
				bit_cnt <= '0;
			end else if (advance) begin
				spi_clk <= !spi_clk; // Half rate of clk
				if (spi_clk) begin
					if (bit_cnt == 6'd63) begin
						busy <= 1'b0;
						spi_csb <= 1'b1; // Deselect between reads
						ready <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 6'd1;
					end
				end
			end
		end
	end

	// Command and address go out MSB first, mosi moves on the falling edge
	always_ff @(posedge clk) begin
		if (start)
			tx_shift <= {spi_read_cmd, addr};
		else if (advance && spi_clk)
			tx_shift <= {tx_shift[30:0], 1'b0};
	end

	// Data bits are taken on the rising edge during the last 32 clocks
	always_ff @(posedge clk) begin
		if (advance && !spi_clk && bit_cnt[5])
			rx_shift <= {rx_shift[30:0], flash_miso};
		if (advance && spi_clk && bit_cnt == 6'd63)
			rdata <= {rx_shift[7:0], rx_shift[15:8], rx_shift[23:16], rx_shift[31:24]};
	end

	assign flash_csb = cfg.f.mem_en ? spi_csb : cfg.f.bb_csb;
	assign flash_clk = cfg.f.mem_en ? spi_clk : cfg.f.bb_clk;
	assign flash_mosi = cfg.f.mem_en ? (!spi_csb && tx_shift[31]) : cfg.f.bb_mosi;

endmodule

`default_nettype wire

// File: verilog/uart_serial.sv
// 8N1 UART with a programmable divider, transmit shifter and one-byte receive buffer
`timescale 1ns/10ps
`default_nettype none

module uart_serial (
	input wire clk,
	input wire rst_n,
	input wire [soc_pkg::strb_w-1:0] div_we,
	input wire [soc_pkg::data_w-1:0] div_wdata,
	output logic [soc_pkg::data_w-1:0] div_rdata,
	input wire dat_we,
	input wire dat_re,
	input wire [7:0] dat_wdata,
	output logic [soc_pkg::data_w-1:0] dat_rdata,
	output logic dat_wait,
	output logic ser_tx,
	input wire ser_rx
);
	import soc_pkg::*;

	logic [data_w-1:0] div; // Clocks per bit
	logic [9:0] tx_shift; // Stop, data, start from left to right
	logic [3:0] tx_bits; // Bits still to send
	logic [data_w-1:0] tx_divcnt;
	logic tx_busy;
	logic [1:0] rx_sync;
	logic rx_in;
	logic [3:0] rx_state; // 0 idle, 1 start, 2 to 9 data, 10 stop
	logic [data_w-1:0] rx_divcnt;
	logic [7:0] rx_shift;
	logic [7:0] rx_buf;
	logic rx_valid;
	logic rx_full_bit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= uart_div_reset;
		end else begin
			for (int i = 0; i < strb_w; i++) begin
				if (div_we[i])
					div[8*i +: 8] <= div_wdata[8*i +: 8];
			end
		end
	end

	assign div_rdata = div;
	assign tx_busy = (tx_bits != 4'd0);
	assign dat_wait = dat_we && tx_busy; // Hold the write until the shifter is free

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_shift <= '1; // Line idles high
			tx_bits <= '0;
			tx_divcnt <= '0;
		end else if (dat_we && !tx_busy) begin
			tx_shift <= {1'b1, dat_wdata, 1'b0};
			tx_bits <= 4'd10;
			tx_divcnt <= '0;
		end else if (tx_busy) begin
			if (tx_divcnt + 32'd1 >= div) begin
				tx_shift <= {1'b1, tx_shift[9:1]}; // LSB first
				tx_bits <= tx_bits - 4'd1;
				tx_divcnt <= '0;
			end else begin
				tx_divcnt <= tx_divcnt + 32'd1;
			end
		end
	end

	assign ser_tx = tx_shift[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], ser_rx};
	end

	assign rx_in = rx_sync[1];
	assign rx_full_bit = (rx_divcnt + 32'd1 >= div);

	// Start bit is checked at half a bit, every later sample lands mid-bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_state <= '0;
			rx_divcnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			if (dat_re)
				rx_valid <= 1'b0;
			case (rx_state)
				4'd0: begin
					rx_divcnt <= '0;
					if (!rx_in)
						rx_state <= 4'd1;
				end
				4'd1: begin
					if (rx_divcnt + 32'd1 >= (div >> 1)) begin
						rx_state <= rx_in ? 4'd0 : 4'd2; // A glitch drops back to idle
						rx_divcnt <= '0;
					end else begin
						rx_divcnt <= rx_divcnt + 32'd1;
					end
				end
				4'd10: begin
					if (rx_full_bit) begin
						rx_state <= '0;
						if (rx_in)
							rx_valid <= 1'b1; // Good stop bit
					end else begin
						rx_divcnt <= rx_divcnt + 32'd1;
					end
				end
				default: begin
					if (rx_full_bit) begin
						rx_state <= rx_state + 4'd1;
						rx_divcnt <= '0;
					end else begin
						rx_divcnt <= rx_divcnt + 32'd1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_state >= 4'd2 && rx_state <= 4'd9 && rx_full_bit)
			rx_shift <= {rx_in, rx_shift[7:1]};
		if (rx_state == 4'd10 && rx_full_bit && rx_in)
			rx_buf <= rx_shift;
	end

	assign dat_rdata = rx_valid ? {24'd0, rx_buf} : '1; // All ones when nothing is waiting

endmodule

`default_nettype wire

// File: verilog/soc_top.sv
// SoC top level joining the bus fabric with the RAM, serial flash reader and UART
`timescale 1ns/10ps
`default_nettype none

module soc_top (
	input wire clk,
	input wire rst_n,

	input wire mem_valid,
	input wire [soc_pkg::addr_w-1:0] mem_addr,
	input wire [soc_pkg::data_w-1:0] mem_wdata,
	input wire [soc_pkg::strb_w-1:0] mem_wstrb,
	output logic mem_ready,
	output logic [soc_pkg::data_w-1:0] mem_rdata,

	output logic iomem_valid,
	input wire iomem_ready,
	output logic [soc_pkg::addr_w-1:0] iomem_addr,
	output logic [soc_pkg::data_w-1:0] iomem_wdata,
	output logic [soc_pkg::strb_w-1:0] iomem_wstrb,
	input wire [soc_pkg::data_w-1:0] iomem_rdata,

	output logic flash_csb,
	output logic flash_clk,
	output logic flash_mosi,
	input wire flash_miso,

	output logic ser_tx,
	input wire ser_rx
);
	import soc_pkg::*;

	logic ram_valid;
	logic ram_ready;
	logic [data_w-1:0] ram_rdata;
	logic flash_valid;
	logic flash_ready;
	logic [data_w-1:0] flash_rdata;
	logic [strb_w-1:0] spi_cfg_we;
	logic [data_w-1:0] spi_cfg_rdata;
	logic [strb_w-1:0] uart_div_we;
	logic [data_w-1:0] uart_div_rdata;
	logic uart_dat_we;
	logic uart_dat_re;
	logic [data_w-1:0] uart_dat_rdata;
	logic uart_dat_wait;

	mem_bus_fabric u_fabric (
		.mem_valid      (mem_valid),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wstrb      (mem_wstrb),
		.mem_ready      (mem_ready),
		.mem_rdata      (mem_rdata),
		.iomem_valid    (iomem_valid),
		.iomem_ready    (iomem_ready),
		.iomem_addr     (iomem_addr),
		.iomem_wdata    (iomem_wdata),
		.iomem_wstrb    (iomem_wstrb),
		.iomem_rdata    (iomem_rdata),
		.ram_valid      (ram_valid),
		.ram_ready      (ram_ready),
		.ram_rdata      (ram_rdata),
		.flash_valid    (flash_valid),
		.flash_ready    (flash_ready),
		.flash_rdata    (flash_rdata),
		.spi_cfg_we     (spi_cfg_we),
		.spi_cfg_rdata  (spi_cfg_rdata),
		.uart_div_we    (uart_div_we),
		.uart_div_rdata (uart_div_rdata),
		.uart_dat_we    (uart_dat_we),
		.uart_dat_re    (uart_dat_re),
		.uart_dat_rdata (uart_dat_rdata),
		.uart_dat_wait  (uart_dat_wait)
	);

	sram_words u_ram (
		.clk   (clk),
		.valid (ram_valid),
		.addr  (mem_addr[ram_addr_w+1:2]), // Byte address to word index
		.wdata (mem_wdata),
		.wstrb (mem_wstrb),
		.ready (ram_ready),
		.rdata (ram_rdata)
	);

	spi_flash_reader u_flash (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid      (flash_valid),
		.addr       (mem_addr[flash_addr_w-1:0]),
		.ready      (flash_ready),
		.rdata      (flash_rdata),
		.cfg_we     (spi_cfg_we),
		.cfg_wdata  (mem_wdata),
		.cfg_rdata  (spi_cfg_rdata),
		.flash_csb  (flash_csb),
		.flash_clk  (flash_clk),
		.flash_mosi (flash_mosi),
		.flash_miso (flash_miso)
	);

	uart_serial u_uart (
		.clk       (clk),
		.rst_n     (rst_n),
		.div_we    (uart_div_we),
		.div_wdata (mem_wdata),
		.div_rdata (uart_div_rdata),
		.dat_we    (uart_dat_we),
		.dat_re    (uart_dat_re),
		.dat_wdata (mem_wdata[7:0]),
		.dat_rdata (uart_dat_rdata),
		.dat_wait  (uart_dat_wait),
		.ser_tx    (ser_tx),
		.ser_rx    (ser_rx)
	);

endmodule

`default_nettype wire

// File: verification/spi_flash_model.sv
// Behavioral SPI flash that answers the read command with a pattern derived from the address
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model (
	input wire flash_csb,
	input wire flash_clk,
	input wire flash_mosi,
	output logic flash_miso
);

	logic [31:0] cmd_addr; // Opcode then 24-bit address, MSB first
	int rise_cnt; // Rising clock edges since select

	function automatic logic [7:0] pattern_byte(input logic [23:0] a);
		logic [23:0] x;
		x = a ^ (a >> 8);
		return x[7:0];
	endfunction

	initial begin
		flash_miso = 1'b0;
		rise_cnt = 0;
		cmd_addr = '0;
	end

	always @(posedge flash_csb) begin
		rise_cnt = 0; // Deselect ends the frame
	end

	// Mode 0, command and address are taken on the rising edge
	always @(posedge flash_clk) begin
		if (!flash_csb) begin
			if (rise_cnt < 32)
				cmd_addr = {cmd_addr[30:0], flash_mosi};
			rise_cnt = rise_cnt + 1;
		end
	end

	// Data moves on the falling edge, bytes in address order, each MSB first
	always @(negedge flash_clk) begin
		int d;
		logic [7:0] b;
		d = rise_cnt - 32;
		if (!flash_csb && rise_cnt >= 32) begin
			b = pattern_byte(cmd_addr[23:0] + 24'(d / 8));
			flash_miso = (cmd_addr[31:24] == 8'h03) ? b[7 - (d % 8)] : 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_soc_assertions.sv
// Protocol assertions on the master bus, the RAM handshake and the flash pins
`timescale 1ns/10ps
`default_nettype none

module tb_soc_assertions (
	input wire clk,
	input wire rst_n,
	input wire mem_valid,
	input wire mem_ready,
	input wire [31:0] mem_addr,
	input wire ram_valid,
	input wire flash_csb,
	input wire flash_clk,
	input wire iomem_valid
);

	// The fabric never completes a transfer nobody asked for
	ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready |-> mem_valid)
		else $error("mem_ready high without mem_valid");

	// A RAM request reaches the master as ready in the following cycle
	ram_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
		ram_valid |=> mem_ready)
		else $error("RAM access did not complete after one wait cycle");

	flash_clk_idle: assert property (@(posedge clk) disable iff (!rst_n)
		flash_csb |-> !flash_clk)
		else $error("flash_clk high while flash_csb is high");

	io_region_only: assert property (@(posedge clk) disable iff (!rst_n)
		iomem_valid |-> (mem_addr[31:24] >= 8'h03))
		else $error("iomem_valid high below the I/O region");

endmodule

`default_nettype wire

// File: verification/tb_soc.sv
// Testbench for the SoC fabric acting as the CPU, with flash model, I/O responder and UART loopback
`timescale 1ns/10ps
`default_nettype none

bind soc_top tb_soc_assertions u_assertions (
	.clk(clk), .rst_n(rst_n), .mem_valid(mem_valid), .mem_ready(mem_ready),
	.mem_addr(mem_addr), .ram_valid(ram_valid),
	.flash_csb(flash_csb), .flash_clk(flash_clk), .iomem_valid(iomem_valid)
);

module tb_soc;
	import soc_pkg::*;

	localparam int clk_period = 40;
	localparam int ram_tests = 16;
	localparam int flash_tests = 8;
	localparam int uart_tests = 6;
	localparam int io_tests = 12;
	localparam logic [31:0] io_xor = 32'h5a5a_c3c3; // Responder read data is address XOR this
	localparam logic [31:0] uart_div_test = 32'd8;
	// Worst case per test with flash frames of about 135 cycles and UART bytes of 10 bits at 8 clocks
	localparam int watchdog_cycles = ram_tests * 3 * 4 + (flash_tests + 1) * 160 +
		uart_tests * (12 * 8 + 20) + io_tests * 8 + 2000;

	logic clk;
	logic rst_n;
	logic mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_wstrb;
	wire mem_ready;
	wire [31:0] mem_rdata;
	wire iomem_valid;
	logic iomem_ready;
	wire [31:0] iomem_addr;
	wire [31:0] iomem_wdata;
	wire [3:0] iomem_wstrb;
	logic [31:0] iomem_rdata;
	wire flash_csb, flash_clk, flash_mosi, flash_miso;
	wire ser_line; // ser_tx looped back to ser_rx
	logic [31:0] lfsr_state;
	logic [31:0] ref_mem [ram_words];
	bit fail_reported;
	bit run_done;

	soc_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.iomem_valid(iomem_valid), .iomem_ready(iomem_ready), .iomem_addr(iomem_addr),
		.iomem_wdata(iomem_wdata), .iomem_wstrb(iomem_wstrb), .iomem_rdata(iomem_rdata),
		.flash_csb(flash_csb), .flash_clk(flash_clk), .flash_mosi(flash_mosi),
		.flash_miso(flash_miso),
		.ser_tx(ser_line), .ser_rx(ser_line)
	);

	spi_flash_model u_flash_model (
		.flash_csb(flash_csb), .flash_clk(flash_clk),
		.flash_mosi(flash_mosi), .flash_miso(flash_miso)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = !clk;
	end

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bc_d35c) : (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]}; // One step per bit taken
		end
		return v;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			fail_reported = 1'b1;
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// Starts at posedge plus 5 ns and returns at the same point after completion
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		mem_valid = 1'b1;
		do @(negedge clk); while (!mem_ready);
		rdata = mem_rdata;
		@(posedge clk);
		#5;
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	function automatic logic [31:0] flash_word(input logic [23:0] off);
		logic [31:0] w;
		logic [23:0] a;
		for (int i = 0; i < 4; i++) begin
			a = off + 24'(i);
			w[8*i +: 8] = a[7:0] ^ a[15:8]; // Low byte of a XOR (a >> 8)
		end
		return w;
	endfunction

	// Answers each I/O request after a few random cycles and checks the pass-through
	initial begin
		logic [31:0] delay;
		iomem_ready = 1'b0;
		iomem_rdata = '0;
		forever begin
			@(negedge clk);
			if (iomem_valid) begin
				check_eq("iomem_addr", mem_addr, iomem_addr);
				check_eq("iomem_wdata", mem_wdata, iomem_wdata);
				check_eq("iomem_wstrb", {28'd0, mem_wstrb}, {28'd0, iomem_wstrb});
				delay = rnd(2);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#5;
				iomem_rdata = iomem_addr ^ io_xor;
				iomem_ready = 1'b1;
				@(posedge clk);
				#5;
				iomem_ready = 1'b0;
			end
		end
	end

	task automatic check_reset_state();
		logic [31:0] rd;
		@(negedge clk);
		check_eq("flash_csb", 32'd1, {31'd0, flash_csb});
		check_eq("flash_clk", 32'd0, {31'd0, flash_clk});
		check_eq("ser_tx", 32'd1, {31'd0, ser_line});
		check_eq("mem_ready", 32'd0, {31'd0, mem_ready});
		check_eq("iomem_valid", 32'd0, {31'd0, iomem_valid});
		@(posedge clk);
		#5;
		bus_access(reg_spi_cfg, '0, 4'h0, rd);
		check_eq("spi_cfg", 32'h8000_0000, rd);
		bus_access(32'h0200_0010, '0, 4'h0, rd);
		check_eq("unmapped_rdata", 32'd0, rd);
	endtask

	task automatic test_ram();
		logic [7:0] idx [ram_tests];
		logic [31:0] w, rd;
		logic [3:0] s;
		for (int i = 0; i < ram_tests; i++) begin
			idx[i] = rnd(8);
			w = rnd(32);
			bus_access({22'd0, idx[i], 2'b00}, w, 4'hf, rd);
			ref_mem[idx[i]] = w;
		end
		for (int i = 0; i < ram_tests; i++) begin
			w = rnd(32);
			s = rnd(4);
			if (s == 4'h0)
				s = 4'h1; // A zero strobe would be a read
			bus_access({22'd0, idx[i], 2'b00}, w, s, rd);
			check_eq("ram_old_word", ref_mem[idx[i]], rd);
			for (int b = 0; b < 4; b++) begin
				if (s[b])
					ref_mem[idx[i]][8*b +: 8] = w[8*b +: 8];
			end
		end
		for (int i = 0; i < ram_tests; i++) begin
			bus_access({22'd0, idx[i], 2'b00}, '0, 4'h0, rd);
			check_eq("ram_rdata", ref_mem[idx[i]], rd);
		end
	endtask

	task automatic flash_read_check();
		logic [21:0] word_idx;
		logic [23:0] off;
		logic [31:0] rd;
		word_idx = rnd(22);
		off = {word_idx, 2'b00};
		bus_access({8'h01, off}, '0, 4'h0, rd);
		check_eq("flash_rdata", flash_word(off), rd);
	endtask

	task automatic test_uart();
		logic [31:0] rd;
		logic [7:0] b;
		bus_access(reg_uart_div, '0, 4'h0, rd);
		check_eq("uart_div_reset", uart_div_reset, rd);
		bus_access(reg_uart_div, uart_div_test, 4'hf, rd);
		bus_access(reg_uart_div, '0, 4'h0, rd);
		check_eq("uart_div", uart_div_test, rd);
		bus_access(reg_uart_dat, '0, 4'h0, rd);
		check_eq("uart_dat_empty", 32'hffff_ffff, rd);
		for (int i = 0; i < uart_tests; i++) begin
			b = rnd(8);
			bus_access(reg_uart_dat, {24'd0, b}, 4'h1, rd);
			do bus_access(reg_uart_dat, '0, 4'h0, rd); while (rd == 32'hffff_ffff);
			check_eq("uart_loopback", {24'd0, b}, rd);
		end
	endtask

	task automatic bitbang_check(input logic csb, input logic sclk, input logic mosi);
		logic [31:0] w, rd;
		w = {23'd0, 1'b1, 2'd0, sclk, csb, 3'd0, mosi}; // Output enable at bit 8, memory mode off
		bus_access(reg_spi_cfg, w, 4'hf, rd);
		@(negedge clk);
		check_eq("flash_csb", {31'd0, csb}, {31'd0, flash_csb});
		check_eq("flash_clk", {31'd0, sclk}, {31'd0, flash_clk});
		check_eq("flash_mosi", {31'd0, mosi}, {31'd0, flash_mosi});
		@(posedge clk);
		#5;
		bus_access(reg_spi_cfg, '0, 4'h0, rd);
		check_eq("spi_cfg", w, rd);
	endtask

	task automatic test_spi_cfg();
		logic [31:0] rd;
		bitbang_check(1'b1, 1'b0, 1'b0);
		bitbang_check(1'b0, 1'b0, 1'b1);
		bitbang_check(1'b0, 1'b1, 1'b1);
		bitbang_check(1'b0, 1'b0, 1'b0);
		bitbang_check(1'b1, 1'b0, 1'b1); // Deselect before handing the pins back
		bus_access(reg_spi_cfg, 32'h8000_0000, 4'hf, rd);
		flash_read_check();
	endtask

	task automatic test_io();
		logic [31:0] addr, w, rd;
		logic [21:0] word_idx;
		logic [7:0] top;
		logic [3:0] s;
		for (int i = 0; i < io_tests; i++) begin
			top = rnd(8);
			if (top < 8'h03)
				top = top + 8'h03;
			word_idx = rnd(22);
			addr = {top, word_idx, 2'b00};
			w = rnd(32);
			s = (i % 2 == 0) ? 4'h0 : rnd(4);
			bus_access(addr, w, s, rd);
			if (s == 4'h0)
				check_eq("io_rdata", addr ^ io_xor, rd);
		end
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
		fail_reported = 1'b1;
		$display("Test FAILED");
		$fatal(1);
	end

	initial begin
		lfsr_state = 32'd27;
		fail_reported = 1'b0;
		run_done = 1'b0;
		rst_n = 1'b0;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		check_reset_state();
		test_ram();
		for (int i = 0; i < flash_tests; i++)
			flash_read_check();
		test_uart();
		test_spi_cfg();
		test_io();
		run_done = 1'b1;
		if (!fail_reported)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// A run stopped by a bound assertion still ends with the fail message
	final begin
		if (!run_done && !fail_reported)
			$display("Test FAILED");
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/soc_pkg.sv
verilog/mem_bus_fabric.sv
verilog/sram_words.sv
verilog/spi_flash_reader.sv
verilog/uart_serial.sv
verilog/soc_top.sv
verification/spi_flash_model.sv
verification/tb_soc_assertions.sv
verification/tb_soc.sv

// File: Makefile
# Verilator build and run of the SoC testbench

VERILATOR ?= verilator
TOP ?= tb_soc
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Test OK
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass when the log holds the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
